/* common/init_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table geometry and reset sequence length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef INIT_SETTINGS_SVH
`define INIT_SETTINGS_SVH

// number of table entries
`define TABLE_DEPTH 32
// bits per entry
`define TABLE_WIDTH 16
// reset hold length in cycles, must cover TABLE_DEPTH
`define RESET_SEQUENCE_CYCLES 40

`endif

/* common/InitPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared table types, reset counter type and access port states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "init_settings.svh"

package InitPkg;

    // entry index
    typedef logic [$clog2(`TABLE_DEPTH)-1:0] TableAddr;

    // entry value
    typedef logic [`TABLE_WIDTH-1:0] TableData;

    // one extra bit so the count can reach the sequence length
    typedef logic [$clog2(`RESET_SEQUENCE_CYCLES):0] ResetCount;

    // four-phase port FSM
    typedef enum logic [1:0] {
        stIdle,
        stAccess,
        stAcknowledge,
        stRelease
    } AccessState;

endpackage

/* design/reset/ResetController.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset sequencer with lock monitoring and start-of-reset pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "init_settings.svh"

module ResetController
    import InitPkg::*;
(
    input  logic clk,
    input  logic rstTrigger,
    input  logic locked,
    output logic rst,
    output logic rstStart
);

    // cycles spent in reset since trigger release
    ResetCount count;

    // trigger is asynchronous, lock loss is seen at the next edge
    always_ff @(posedge clk or posedge rstTrigger) begin
        if (rstTrigger) begin
            count <= '0;
            rst   <= 1'b1;
        end else if (!locked) begin
            // clock source unstable, restart the sequence
            count <= '0;
            rst   <= 1'b1;
        end else if (rst) begin
            count <= count + 1'b1;
            // release once the count reaches the sequence length
            if (count >= ResetCount'(`RESET_SEQUENCE_CYCLES)) begin
                rst <= 1'b0;
            end
        end else begin
            count <= '0;
            rst   <= 1'b0;
        end
    end

    // first reset cycle only
    // init logic runs under rst, so it restarts from this pulse instead
    always_comb begin
        rstStart = rst && (count == '0);
    end

endmodule

/* design/table/TableInitializer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table initializer sweeping every entry with its own index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "init_settings.svh"

module TableInitializer
    import InitPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rstStart,
    output logic     initWrite,
    output TableAddr initAddr,
    output TableData initData
);

    // last entry of the sweep
    localparam TableAddr LastAddr = TableAddr'(`TABLE_DEPTH - 1);

    // rstStart restarts the sweep
    always_ff @(posedge clk) begin
        if (rstStart) begin
            // arm the sweep for a first write next cycle
            initAddr  <= '0;
            initWrite <= 1'b1;
        end else if (initWrite) begin
            if (!rst) begin
                // abandon the sweep when reset ends early
                initWrite <= 1'b0;
            end else if (initAddr == LastAddr) begin
                // last entry written so hold until the next start
                initWrite <= 1'b0;
            end else begin
                initAddr <= initAddr + 1'b1;
            end
        end
    end

    // entry i holds i
    // zero extended to the entry width
    always_comb begin
        initData = TableData'(initAddr);
    end

endmodule

/* design/table/TableRam.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port table RAM, synchronous write and registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "init_settings.svh"

module TableRam
    import InitPkg::*;
(
    input  logic     clk,
    input  logic     ramWrite,
    input  TableAddr ramAddr,
    input  TableData ramWrData,
    output TableData ramRdData
);

    // storage array
    TableData mem [`TABLE_DEPTH];

    always_ff @(posedge clk) begin
        // write port
        if (ramWrite) begin
            mem[ramAddr] <= ramWrData;
        end
        // read returns the old entry on a write cycle
        ramRdData <= mem[ramAddr];
    end

endmodule

/* design/AccessController.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM port mux and four-phase req/ack FSM for table access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module AccessController
    import InitPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // initializer write path
    input  logic     initWrite,
    input  TableAddr initAddr,
    input  TableData initData,
    // outside requester
    input  logic     req,
    input  logic     reqWrite,
    input  TableAddr reqAddr,
    input  TableData reqData,
    output logic     ack,
    output TableData rdData,
    // table RAM
    output logic     ramWrite,
    output TableAddr ramAddr,
    output TableData ramWrData,
    input  TableData ramRdData
);

    AccessState state;
    AccessState nextState;

    // request accepted this cycle
    logic issue;

    always_comb begin
        issue = (state == stIdle) && req;
    end

    // next state for the handshake
    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (req) begin
                    nextState = stAccess;
                end
            end
            // RAM read data registers during this cycle
            stAccess: begin
                nextState = stAcknowledge;
            end
            // hold ack until the requester lets go
            stAcknowledge: begin
                if (!req) begin
                    nextState = stRelease;
                end
            end
            stRelease: begin
                nextState = stIdle;
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    // rst doubles as the busy condition, so requests wait here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stIdle;
            ack   <= 1'b0;
        end else begin
            state <= nextState;
            ack   <= (nextState == stAcknowledge) || (nextState == stRelease);
        end
    end

    // capture read data together with the rising ack
    always_ff @(posedge clk) begin
        if (state == stAccess) begin
            rdData <= ramRdData;
        end
    end

    // RAM port owner
    // initializer during reset, requester afterwards
    always_comb begin
        if (rst) begin
            ramWrite  = initWrite;
            ramAddr   = initAddr;
            ramWrData = initData;
        end else begin
            ramWrite  = issue && reqWrite;
            ramAddr   = reqAddr;
            ramWrData = reqData;
        end
    end

endmodule

/* design/InitTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the reset-sequenced table subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module InitTop (
    input  logic             clk,
    input  logic             rstTrigger,
    input  logic             locked,
    input  logic             req,
    input  logic             reqWrite,
    input  InitPkg::TableAddr reqAddr,
    input  InitPkg::TableData reqData,
    output logic             ack,
    output InitPkg::TableData rdData,
    output logic             initBusy
);

    // sequenced reset
    logic rst;
    logic rstStart;

    // initializer write path
    logic              initWrite;
    InitPkg::TableAddr initAddr;
    InitPkg::TableData initData;

    // RAM port
    logic              ramWrite;
    InitPkg::TableAddr ramAddr;
    InitPkg::TableData ramWrData;
    InitPkg::TableData ramRdData;

    ResetController resetCtrl (
        .clk        (clk),
        .rstTrigger (rstTrigger),
        .locked     (locked),
        .rst        (rst),
        .rstStart   (rstStart)
    );

    TableInitializer tableInit (
        .clk       (clk),
        .rst       (rst),
        .rstStart  (rstStart),
        .initWrite (initWrite),
        .initAddr  (initAddr),
        .initData  (initData)
    );

    TableRam tableRam (
        .clk       (clk),
        .ramWrite  (ramWrite),
        .ramAddr   (ramAddr),
        .ramWrData (ramWrData),
        .ramRdData (ramRdData)
    );

    AccessController accessCtrl (
        .clk       (clk),
        .rst       (rst),
        .initWrite (initWrite),
        .initAddr  (initAddr),
        .initData  (initData),
        .req       (req),
        .reqWrite  (reqWrite),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .ack       (ack),
        .rdData    (rdData),
        .ramWrite  (ramWrite),
        .ramAddr   (ramAddr),
        .ramWrData (ramWrData),
        .ramRdData (ramRdData)
    );

    // busy for the whole reset window
    assign initBusy = rst;

endmodule

/* sim/InitTopTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace-driven testbench for the reset-sequenced table subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "init_settings.svh"

module InitTopTb
    import InitPkg::*;
();

    localparam int ClockPeriod  = 40;
    localparam int ReleaseEdges = `RESET_SEQUENCE_CYCLES + 1;
    localparam int TraceMax     = 256;

    logic     clk;
    logic     rstTrigger;
    logic     locked;
    logic     req;
    logic     reqWrite;
    TableAddr reqAddr;
    TableData reqData;
    logic     ack;
    TableData rdData;
    logic     initBusy;

    // op is 0 for access, 1 for lock drop, 2 for trigger
    logic [31:0] opList     [TraceMax];
    logic [31:0] writeList  [TraceMax];
    logic [31:0] addrList   [TraceMax];
    logic [31:0] dataList   [TraceMax];
    logic [31:0] expectList [TraceMax];
    int          traceLength;

    int     errorCount;
    int     checkCount;
    int     cycleCount;
    int     cycleLimit;
    integer seed;

    InitTop UUT (
        .clk        (clk),
        .rstTrigger (rstTrigger),
        .locked     (locked),
        .req        (req),
        .reqWrite   (reqWrite),
        .reqAddr    (reqAddr),
        .reqData    (reqData),
        .ack        (ack),
        .rdData     (rdData),
        .initBusy   (initBusy)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    // run limit armed once the trace length is known
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, a handshake or reset never completed",
                     cycleCount);
            $display("%0d errors in %0d checks", errorCount + 1, checkCount);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s expected %h got %h", $time, name,
                     expected, actual);
            errorCount++;
        end
    endtask

    // comment lines in the trace fail the scan and are skipped
    task automatic readTrace();
        int          fd;
        int          got;
        int          fields;
        string       line;
        logic [31:0] op;
        logic [31:0] wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        traceLength = 0;
        fd = $fopen("sim/access_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file sim/access_trace.txt");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got = $fgets(line, fd);
                fields = $sscanf(line, "%h %h %h %h %h", op, wr, addr, data, expected);
                if (got > 0 && fields == 5 && traceLength < TraceMax) begin
                    opList[traceLength]     = op;
                    writeList[traceLength]  = wr;
                    addrList[traceLength]   = addr;
                    dataList[traceLength]   = data;
                    expectList[traceLength] = expected;
                    traceLength++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ack must stay low while req is low
    task automatic idleCycles(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (ack !== 1'b0) begin
                $display("%0d ns: ack is high while req is low", $time);
                errorCount++;
            end
        end
    endtask

    // bounded wait for ack to reach the level
    task automatic waitAck(input logic level, output int edges);
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (ack !== level && edges < 8);
    endtask

    // counts edges until initBusy falls and checks that ack stays low
    task automatic waitRelease(input string cause);
        int edges;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
            if (ack !== 1'b0) begin
                $display("%0d ns: ack is high during reset", $time);
                errorCount++;
            end
        end while (initBusy === 1'b1 && edges < 4 * `RESET_SEQUENCE_CYCLES);
        checkCount++;
        if (initBusy !== 1'b0) begin
            $display("%0d ns: initBusy still high %0d edges after %s", $time, edges, cause);
            errorCount++;
        end else if (edges != ReleaseEdges) begin
            $display("mismatch at %0d ns: initBusy release edges after %s expected %0d got %0d",
                     $time, cause, ReleaseEdges, edges);
            errorCount++;
        end
    endtask

    // rest of a four-phase cycle once req is up
    task automatic finishAccess(input int index);
        int edges;
        waitAck(1'b1, edges);
        checkCount++;
        if (ack !== 1'b1) begin
            $display("%0d ns: ack never rose for trace entry %0d", $time, index);
            errorCount++;
        end else if (edges != 2) begin
            $display("%0d ns: ack rose %0d edges after req instead of 2", $time, edges);
            errorCount++;
        end
        // read data valid together with ack
        if (writeList[index] == 0) begin
            checkValue("rdData", expectList[index], 32'(rdData));
        end
        req = 1'b0;
        waitAck(1'b0, edges);
        checkCount++;
        if (ack !== 1'b0) begin
            $display("%0d ns: ack never fell after req dropped", $time);
            errorCount++;
        end else if (edges != 2) begin
            $display("%0d ns: ack fell %0d edges after req dropped instead of 2", $time, edges);
            errorCount++;
        end
    endtask

    task automatic raiseReq(input int index);
        reqWrite = writeList[index][0];
        reqAddr  = TableAddr'(addrList[index]);
        reqData  = TableData'(dataList[index]);
        req      = 1'b1;
    endtask

    // lock loss restarts the whole sequence
    task automatic dropLock();
        locked = 1'b0;
        @(negedge clk);
        checkCount++;
        if (initBusy !== 1'b1) begin
            $display("%0d ns: initBusy did not rise after lock loss", $time);
            errorCount++;
        end
        locked = 1'b1;
        waitRelease("lock recovery");
    endtask

    task automatic pulseTrigger();
        rstTrigger = 1'b1;
        // trigger acts before any clock edge
        #1;
        checkCount++;
        if (initBusy !== 1'b1) begin
            $display("%0d ns: initBusy did not rise with rstTrigger", $time);
            errorCount++;
        end
        repeat (3) @(negedge clk);
        rstTrigger = 1'b0;
        waitRelease("trigger release");
    endtask

    initial begin
        int gap;
        seed        = 32'h697;
        errorCount  = 0;
        checkCount  = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        rstTrigger  = 1'b1;
        locked      = 1'b1;
        req         = 1'b0;
        reqWrite    = 1'b0;
        reqAddr     = '0;
        reqData     = '0;
        readTrace();
        cycleLimit = traceLength * 10 + 4 * `RESET_SEQUENCE_CYCLES;
        if (traceLength == 0) begin
            $display("the trace file holds no entries");
            errorCount++;
        end else begin
            @(negedge clk);
            checkValue("initBusy", 32'd1, 32'(initBusy));
            // first entry waits through reset as a pending request
            raiseReq(0);
            for (int i = 0; i < 9; i++) begin
                @(negedge clk);
                checkCount++;
                if (ack !== 1'b0) begin
                    $display("%0d ns: ack is high while the trigger is held", $time);
                    errorCount++;
                end
            end
            rstTrigger = 1'b0;
            waitRelease("power-up trigger release");
            finishAccess(0);
            for (int i = 1; i < traceLength; i++) begin
                gap = {$random(seed)} % 4;
                idleCycles(gap);
                if (opList[i] == 1) begin
                    dropLock();
                end else if (opList[i] == 2) begin
                    pulseTrigger();
                end else begin
                    raiseReq(i);
                    finishAccess(i);
                end
            end
            idleCycles(2);
        end
        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim/access_trace.txt */
// op (0 access, 1 lock drop, 2 trigger), write flag, address, write data, expected read
// all hex, expected read only checked on reads, first entry waits through reset
0 0 05 0000 0005
0 0 00 0000 0000
0 0 01 0000 0001
0 0 02 0000 0002
0 0 03 0000 0003
0 0 07 0000 0007
0 0 0a 0000 000a
0 0 0f 0000 000f
0 0 10 0000 0010
0 0 15 0000 0015
0 0 1e 0000 001e
0 0 1f 0000 001f
0 1 03 abcd 0000
0 0 03 0000 abcd
0 0 02 0000 0002
0 0 04 0000 0004
0 1 1f 1234 0000
0 1 10 beef 0000
0 0 1f 0000 1234
0 0 10 0000 beef
0 0 0f 0000 000f
0 0 11 0000 0011
1 0 00 0000 0000
0 0 03 0000 0003
0 0 1f 0000 001f
0 0 10 0000 0010
0 1 07 5a5a 0000
0 0 07 0000 5a5a
0 0 08 0000 0008
2 0 00 0000 0000
0 0 07 0000 0007
0 0 00 0000 0000
0 0 1d 0000 001d
0 1 00 ffff 0000
0 0 00 0000 ffff
0 0 01 0000 0001

/* project.f */
+incdir+common
common/InitPkg.sv
design/reset/ResetController.sv
design/table/TableInitializer.sv
design/table/TableRam.sv
design/AccessController.sv
design/InitTop.sv
sim/InitTopTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the table init testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps \
    -f project.f \
    --top-module InitTopTb \
    -o InitTopTbSim

# trace path is relative to the project root
./obj_dir/InitTopTbSim | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi
